//--- Makefile
VERILATOR  := verilator
FILELIST   := project.f
TOP        := snac_adapter_tb
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the test result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/cart_port_map.sv
`timescale 1ns/1ps

module cart_port_map (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_lat,
    input  logic       i_pad_clk,
    input  logic [7:4] i_cart_bk0,
    output logic       o_dat1,
    output logic       o_dat2,
    output logic       o_cart_bk0_dir,
    output logic [7:6] o_cart_bk1,
    output logic       o_cart_pin30,
    output logic       o_cart_pin30_dir,
    output logic       o_cart_pin31_dir
);
    // Configuration A pinout for NES/SNES
    // bank0[4] RX-  player 1 data in
    // bank0[5] TX+  player 2 data in
    // bank1[6] D-   pad clock out
    // bank1[7] D+   latch out
    // pin30    GND_D second copy of the pad clock
    // bank0[7:6] carry nothing for these pads

    logic [1:0] meta_q;   // [0] player 1, [1] player 2
    logic [1:0] sync_q;
    logic [7:6] bk1_q;
    logic       pin30_q;

    // Two-flop synchronizer on the pad data
    always_ff @(posedge i_clk) begin
        meta_q <= i_cart_bk0[5:4];
        sync_q <= meta_q;
    end

    // Output registers keep the pins glitch free
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            bk1_q   <= 2'b00;
            pin30_q <= 1'b0;
        end else begin
            bk1_q   <= {i_lat, i_pad_clk};
            pin30_q <= i_pad_clk;
        end
    end

    assign o_dat1 = sync_q[0];
    assign o_dat2 = sync_q[1];

    assign o_cart_bk1       = bk1_q;
    assign o_cart_pin30     = pin30_q;
    assign o_cart_bk0_dir   = 1'b0;   // Input
    assign o_cart_pin30_dir = 1'b1;   // Output
    assign o_cart_pin31_dir = 1'b0;   // Input, unused

endmodule

//--- hdl/poll_rate_sel.sv
`timescale 1ns/1ps
`include "snac_params.svh"

module poll_rate_sel (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  snac_ctrl_pkg::gc_type_e      i_game_cont_type,
    input  snac_ctrl_pkg::sample_rate_e  i_sample_rate,
    output snac_ctrl_pkg::gc_type_e      o_type,
    output logic [`SNAC_ACC_W-1:0]       o_step,
    output logic                         o_restart
);
    import snac_ctrl_pkg::*;

    localparam int ACC_W = `SNAC_ACC_W;

    // Step = 2^ACC_W * 2 * f_poll / f_clk
    // Carry rate of the accumulator is then twice the polling rate
    function automatic logic [ACC_W-1:0] calc_step(input longint unsigned freq);
        longint unsigned range;
        range = 64'd1 << ACC_W;
        return ACC_W'((range * 64'd2 * freq) / 64'(`SNAC_CLK_FREQ));
    endfunction

    localparam logic [ACC_W-1:0] STEP_COMPAT = calc_step(`SNAC_POLL_COMPAT);
    localparam logic [ACC_W-1:0] STEP_NORMAL = calc_step(`SNAC_POLL_NORMAL);
    localparam logic [ACC_W-1:0] STEP_FAST   = calc_step(`SNAC_POLL_FAST);
    localparam logic [ACC_W-1:0] STEP_VFAST  = calc_step(`SNAC_POLL_VFAST);

    gc_type_e         type_q;
    sample_rate_e     rate_q;
    logic             chg_q;   // Settings moved since last cycle
    logic [ACC_W-1:0] step_q;

    // Settings capture and change detect
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            type_q <= GC_DISABLED;
            rate_q <= RATE_COMPAT;
            chg_q  <= 1'b1;
        end else begin
            type_q <= i_game_cont_type;
            rate_q <= i_sample_rate;
            chg_q  <= (type_q != i_game_cont_type) || (rate_q != i_sample_rate);
        end
    end

    // Step lookup, one cycle behind the registered settings
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            step_q <= '0;
        end else if (!gc_is_serlatch(type_q)) begin
            step_q <= '0;                                   // No strobes when disabled
        end else begin
            case (rate_q)
                RATE_NORMAL: step_q <= STEP_NORMAL;
                RATE_FAST:   step_q <= STEP_FAST;
                RATE_VFAST:  step_q <= STEP_VFAST;
                default:     step_q <= STEP_COMPAT;         // Compat and codes 4..7
            endcase
        end
    end

    assign o_type    = type_q;
    assign o_step    = step_q;
    assign o_restart = i_rst | chg_q;    // Restart divider and reader together

    // Outside the restart window a disabled type never carries a step
    a_step_zero_off: assert property (@(posedge i_clk) disable iff (i_rst)
        !gc_is_serlatch(o_type) && !o_restart |-> (o_step == '0));

endmodule

//--- hdl/serlatch_pkg.sv
`include "snac_params.svh"

package serlatch_pkg;

    // Reader FSM, one step per strobe except SL_DONE
    typedef enum logic [2:0] {
        SL_IDLE,    // Waiting for the strobe that opens a frame
        SL_LATCH,   // Latch high, pads load their buttons
        SL_CLK_LO,  // Data bit settles, sampled at the end
        SL_CLK_HI,  // Rising clock shifts the pads
        SL_DONE     // Publish both button words
    } serlat_state_e;

    // Bit k high when button k is pressed
    typedef logic [`SNAC_BTN_W-1:0] btn_state_t;

endpackage

//--- hdl/serlatch_reader.sv
`timescale 1ns/1ps
`include "snac_params.svh"

module serlatch_reader (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  snac_ctrl_pkg::gc_type_e  i_type,
    input  logic                     i_stb,
    input  logic                     i_dat1,    // Player 1 data, active low
    input  logic                     i_dat2,    // Player 2 data, active low
    output logic                     o_lat,     // Shared latch
    output logic                     o_clk,     // Shared pad clock
    output serlatch_pkg::btn_state_t o_p1_btn,
    output serlatch_pkg::btn_state_t o_p2_btn,
    output logic                     o_busy
);
    import snac_ctrl_pkg::*;
    import serlatch_pkg::*;

    localparam int BTN_W     = `SNAC_BTN_W;
    localparam int NES_BITS  = 8;
    localparam int NES_SHIFT = BTN_W - NES_BITS;   // NES bits land in the top byte

    serlat_state_e state_q;
    logic [3:0]    bit_cnt_q;   // Latch strobes, then bit index
    logic [3:0]    last_bit;
    logic          lat_q;
    logic          clk_q;
    logic          busy_q;
    btn_state_t    sr1_q;
    btn_state_t    sr2_q;
    btn_state_t    p1_q;
    btn_state_t    p2_q;

    assign last_bit = (i_type == GC_SNES) ? 4'd15 : 4'd7;

    always_ff @(posedge i_clk) begin
        if (i_rst || !gc_is_serlatch(i_type)) begin
            state_q   <= SL_IDLE;   // Idle with lines low when disabled
            bit_cnt_q <= '0;
            lat_q     <= 1'b0;
            clk_q     <= 1'b0;
            busy_q    <= 1'b0;
            p1_q      <= '0;
            p2_q      <= '0;
        end else begin
            case (state_q)
                SL_IDLE: if (i_stb) begin
                    state_q   <= SL_LATCH;
                    lat_q     <= 1'b1;
                    busy_q    <= 1'b1;
                    bit_cnt_q <= '0;
                end
                SL_LATCH: if (i_stb) begin
                    if (bit_cnt_q == 4'd1) begin     // Latch held for two strobes
                        lat_q     <= 1'b0;
                        bit_cnt_q <= '0;
                        state_q   <= SL_CLK_LO;
                    end else begin
                        bit_cnt_q <= bit_cnt_q + 4'd1;
                    end
                end
                SL_CLK_LO: if (i_stb) begin
                    clk_q   <= 1'b1;                 // Sample taken this strobe
                    state_q <= SL_CLK_HI;
                end
                SL_CLK_HI: if (i_stb) begin
                    clk_q <= 1'b0;
                    if (bit_cnt_q == last_bit) begin
                        state_q <= SL_DONE;
                    end else begin
                        bit_cnt_q <= bit_cnt_q + 4'd1;
                        state_q   <= SL_CLK_LO;
                    end
                end
                SL_DONE: begin
                    // Both players change on the same cycle as busy falls
                    p1_q    <= (i_type == GC_SNES) ? sr1_q : (sr1_q >> NES_SHIFT);
                    p2_q    <= (i_type == GC_SNES) ? sr2_q : (sr2_q >> NES_SHIFT);
                    busy_q  <= 1'b0;
                    state_q <= SL_IDLE;
                end
                default: state_q <= SL_IDLE;
            endcase
        end
    end

    // First bit read ends up in bit 0
    always_ff @(posedge i_clk) begin
        if (state_q == SL_CLK_LO && i_stb) begin
            sr1_q <= {~i_dat1, sr1_q[BTN_W-1:1]};   // Pads are active low
            sr2_q <= {~i_dat2, sr2_q[BTN_W-1:1]};
        end
    end

    assign o_lat    = lat_q;
    assign o_clk    = clk_q;
    assign o_busy   = busy_q;
    assign o_p1_btn = p1_q;
    assign o_p2_btn = p2_q;

    a_lat_clk_excl: assert property (@(posedge i_clk) disable iff (i_rst)
        !(o_lat && o_clk));

    a_idle_not_busy: assert property (@(posedge i_clk) disable iff (i_rst)
        (state_q == SL_IDLE) |-> !o_busy);

endmodule

//--- hdl/snac_adapter_top.sv
`timescale 1ns/1ps
`include "snac_params.svh"

module snac_adapter_top (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  snac_ctrl_pkg::gc_type_e     i_game_cont_type,
    input  snac_ctrl_pkg::sample_rate_e i_sample_rate,
    input  logic [7:4]                  i_cart_bk0,
    output serlatch_pkg::btn_state_t    o_p1_btn,
    output serlatch_pkg::btn_state_t    o_p2_btn,
    output logic                        o_busy,
    output logic                        o_cart_bk0_dir,
    output logic [7:6]                  o_cart_bk1,
    output logic                        o_cart_pin30,
    output logic                        o_cart_pin30_dir,
    output logic                        o_cart_pin31_dir
);
    snac_ctrl_pkg::gc_type_e type_w;
    logic [`SNAC_ACC_W-1:0]  step_w;
    logic                    restart_w;   // Reset or settings change
    logic                    stb_w;       // Twice the polling rate
    logic                    lat_w;
    logic                    pad_clk_w;
    logic                    dat1_w;
    logic                    dat2_w;

    poll_rate_sel poll_rate_sel_i (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_game_cont_type (i_game_cont_type),
        .i_sample_rate    (i_sample_rate),
        .o_type           (type_w),
        .o_step           (step_w),
        .o_restart        (restart_w)
    );

    strobe_divider strobe_divider_i (
        .i_clk  (i_clk),
        .i_rst  (restart_w),
        .i_step (step_w),
        .o_stb  (stb_w)
    );

    serlatch_reader serlatch_reader_i (
        .i_clk    (i_clk),
        .i_rst    (restart_w),
        .i_type   (type_w),
        .i_stb    (stb_w),
        .i_dat1   (dat1_w),
        .i_dat2   (dat2_w),
        .o_lat    (lat_w),
        .o_clk    (pad_clk_w),
        .o_p1_btn (o_p1_btn),
        .o_p2_btn (o_p2_btn),
        .o_busy   (o_busy)
    );

    cart_port_map cart_port_map_i (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_lat            (lat_w),
        .i_pad_clk        (pad_clk_w),
        .i_cart_bk0       (i_cart_bk0),
        .o_dat1           (dat1_w),
        .o_dat2           (dat2_w),
        .o_cart_bk0_dir   (o_cart_bk0_dir),
        .o_cart_bk1       (o_cart_bk1),
        .o_cart_pin30     (o_cart_pin30),
        .o_cart_pin30_dir (o_cart_pin30_dir),
        .o_cart_pin31_dir (o_cart_pin31_dir)
    );

endmodule

//--- hdl/snac_ctrl_pkg.sv
package snac_ctrl_pkg;

    // Controller type code as set by the core menu
    // Codes that are not listed here behave as disabled
    typedef enum logic [4:0] {
        GC_DISABLED = 5'd0,
        GC_NES      = 5'd2,  // 8 bits per frame
        GC_SNES     = 5'd3   // 16 bits per frame
    } gc_type_e;

    // Polling rate selection
    // Codes 4 to 7 fall back to compatibility
    typedef enum logic [2:0] {
        RATE_COMPAT = 3'd0,
        RATE_NORMAL = 3'd1,
        RATE_FAST   = 3'd2,
        RATE_VFAST  = 3'd3
    } sample_rate_e;

    // High for the pad types read by the serial-latch reader
    function automatic logic gc_is_serlatch(gc_type_e t);
        return (t == GC_NES) || (t == GC_SNES);
    endfunction

endpackage

//--- hdl/snac_params.svh
`ifndef SNAC_PARAMS_SVH
`define SNAC_PARAMS_SVH

// Master clock of the core in Hz
`define SNAC_CLK_FREQ    50_000_000

// Pad polling rates in Hz
// The reader FSM steps on a strobe at twice these rates
`define SNAC_POLL_COMPAT 100_000   // Slowest, safe for old or clone pads
`define SNAC_POLL_NORMAL 200_000
`define SNAC_POLL_FAST   400_000
`define SNAC_POLL_VFAST  1_000_000 // Only for short cables

// Phase accumulator of the fractional strobe divider
`define SNAC_ACC_W       32

// One player's button word
// NES pads fill the low 8 bits and SNES pads fill all 16
`define SNAC_BTN_W       16

`endif

//--- hdl/strobe_divider.sv
`timescale 1ns/1ps
`include "snac_params.svh"

module strobe_divider (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic [`SNAC_ACC_W-1:0] i_step,
    output logic                   o_stb
);
    localparam int ACC_W = `SNAC_ACC_W;

    logic [ACC_W-1:0] acc_q;
    logic [ACC_W:0]   sum;    // Top bit is the carry
    logic             stb_q;

    assign sum = {1'b0, acc_q} + {1'b0, i_step};

    // Phase accumulator
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            acc_q <= '0;
            stb_q <= 1'b0;
        end else begin
            acc_q <= sum[ACC_W-1:0];
            stb_q <= sum[ACC_W];      // One pulse per wrap
        end
    end

    assign o_stb = stb_q;

    // Steps stay far below half the range, so the wraps never touch
    a_stb_single: assert property (@(posedge i_clk) disable iff (i_rst)
        o_stb |=> !o_stb);

endmodule

//--- project.f
+incdir+hdl
hdl/snac_ctrl_pkg.sv
hdl/serlatch_pkg.sv
hdl/poll_rate_sel.sv
hdl/strobe_divider.sv
hdl/serlatch_reader.sv
hdl/cart_port_map.sv
hdl/snac_adapter_top.sv
verification/snac_pad_model.sv
verification/snac_adapter_tb.sv

//--- verification/snac_adapter_tb.sv
`timescale 1ns/1ps
`include "snac_params.svh"

module snac_adapter_tb;
    import snac_ctrl_pkg::*;
    import serlatch_pkg::*;

    localparam int CLK_HALF     = 4;       // 8 ns period
    localparam int RST_CYC      = 8;
    localparam int RATE_WIN     = 20000;   // Latch count window in cycles
    // Slowest rate in use is compat, an SNES frame there is 35 strobes
    localparam int STB_CYC_MAX  = `SNAC_CLK_FREQ / (2 * `SNAC_POLL_COMPAT);
    localparam int FRAME_CYC    = 35 * STB_CYC_MAX;
    localparam int WATCHDOG_CYC = 20 * FRAME_CYC + 2 * RATE_WIN + 1000;

    logic          clk;
    logic          rst;
    gc_type_e      cur_type;
    sample_rate_e  cur_rate;
    logic [7:4]    cart_bk0;
    btn_state_t    p1_btn;
    btn_state_t    p2_btn;
    logic          busy;
    logic          bk0_dir;
    logic [7:6]    cart_bk1;     // [7] latch, [6] pad clock
    logic          pin30;
    logic          pin30_dir;
    logic          pin31_dir;
    logic          dat1;
    logic          dat2;
    btn_state_t    pat1;         // Buttons held on each pad
    btn_state_t    pat2;
    btn_state_t    frame_pat1;   // What the pads loaded for the current frame
    btn_state_t    frame_pat2;
    gc_type_e      frame_type;
    logic          lat_d;
    int            latch_cnt;
    int            dis_cnt;      // Cycles spent with a disabled type
    int            n_normal;
    int            n_vfast;
    string         test_name;
    serlat_state_e reader_state;

    snac_adapter_top snac_adapter_top_i (
        .i_clk            (clk),
        .i_rst            (rst),
        .i_game_cont_type (cur_type),
        .i_sample_rate    (cur_rate),
        .i_cart_bk0       (cart_bk0),
        .o_p1_btn         (p1_btn),
        .o_p2_btn         (p2_btn),
        .o_busy           (busy),
        .o_cart_bk0_dir   (bk0_dir),
        .o_cart_bk1       (cart_bk1),
        .o_cart_pin30     (pin30),
        .o_cart_pin30_dir (pin30_dir),
        .o_cart_pin31_dir (pin31_dir)
    );

    snac_pad_model pad1_i (.i_lat(cart_bk1[7]), .i_pad_clk(cart_bk1[6]),
                           .i_pattern(pat1), .o_dat(dat1));
    snac_pad_model pad2_i (.i_lat(cart_bk1[7]), .i_pad_clk(cart_bk1[6]),
                           .i_pattern(pat2), .o_dat(dat2));

    assign cart_bk0     = {2'b11, dat2, dat1};   // Bits 7:6 idle high
    assign reader_state = snac_adapter_top_i.serlatch_reader_i.state_q;

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    task automatic stop_on_error();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic fail_value(input string name, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
        $display("Error %s: expected 'h%0h, actual 'h%0h", name, exp_v, act_v);
        stop_on_error();
    endtask

    task automatic fail_plain(input string what);
        $display("%s", what);
        stop_on_error();
    endtask

    // NES fills the low byte only, SNES the whole word
    function automatic btn_state_t expected_word(input btn_state_t pattern,
                                                 input gc_type_e t);
        if (t == GC_SNES) begin
            return pattern;
        end
        return btn_state_t'(pattern[7:0]);
    endfunction

    // Track the latch pin, the pads load on its rising edge
    always @(posedge clk) begin
        if (rst) begin
            lat_d     <= 1'b0;
            latch_cnt <= 0;
        end else begin
            lat_d <= cart_bk1[7];
            if (cart_bk1[7] && !lat_d) begin
                frame_pat1 <= pat1;
                frame_pat2 <= pat2;
                frame_type <= cur_type;
                latch_cnt  <= latch_cnt + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst || cur_type == GC_NES || cur_type == GC_SNES) begin
            dis_cnt <= 0;
        end else if (dis_cnt < 15) begin
            dis_cnt <= dis_cnt + 1;
        end
    end

    a_pin_dirs: assert property (@(posedge clk)
        {bk0_dir, pin30_dir, pin31_dir} == 3'b010)
        else fail_value("pin_dirs", 32'h2, 32'({bk0_dir, pin30_dir, pin31_dir}));

    a_lat_clk: assert property (@(posedge clk) disable iff (rst)
        !(cart_bk1[7] && cart_bk1[6]))
        else fail_plain("Latch and pad clock are high together on bank1");

    a_pin30_copy: assert property (@(posedge clk) disable iff (rst)
        pin30 == cart_bk1[6])
        else fail_value("pin30_copy", 32'(cart_bk1[6]), 32'(pin30));

    // Words are published on the cycle busy falls
    a_frame_p1: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> (p1_btn == expected_word(frame_pat1, frame_type)))
        else fail_value(test_name, 32'(expected_word(frame_pat1, frame_type)),
                        32'(p1_btn));

    a_frame_p2: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> (p2_btn == expected_word(frame_pat2, frame_type)))
        else fail_value(test_name, 32'(expected_word(frame_pat2, frame_type)),
                        32'(p2_btn));

    a_frame_end: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> ($past(reader_state) == SL_DONE))
        else fail_plain("Busy fell while the reader was not finishing a frame");

    // Disabled pads: words cleared, lines parked low
    a_dis_words: assert property (@(posedge clk) disable iff (rst)
        (dis_cnt >= 4) |-> ({p1_btn, p2_btn} == '0))
        else fail_value(test_name, 32'h0, {p1_btn, p2_btn});

    a_dis_lines: assert property (@(posedge clk) disable iff (rst)
        (dis_cnt >= 4) |-> ({busy, pin30, cart_bk1} == 4'b0000))
        else fail_value(test_name, 32'h0, 32'({busy, pin30, cart_bk1}));

    task automatic new_patterns();
        pat1 = btn_state_t'($urandom);
        pat2 = btn_state_t'($urandom);
    endtask

    task automatic set_mode(input gc_type_e t, input sample_rate_e r);
        cur_type = t;
        cur_rate = r;
    endtask

    // Count busy falls, fresh buttons for every following frame
    task automatic wait_frames(input int n);
        int   done;
        logic prev;
        done = 0;
        prev = busy;
        while (done < n) begin
            @(negedge clk);
            if (prev && !busy) begin
                done++;
                new_patterns();
            end
            prev = busy;
        end
    endtask

    task automatic count_latches(input sample_rate_e r, output int n);
        int start;
        set_mode(GC_SNES, r);
        start = latch_cnt;
        repeat (RATE_WIN) @(negedge clk);
        n = latch_cnt - start;
        wait_frames(1);   // Next switch lands between frames
    endtask

    task automatic check_reset_state();
        assert ({p1_btn, p2_btn} == '0)
            else fail_value("reset_words", 32'h0, {p1_btn, p2_btn});
        assert ({busy, pin30, cart_bk1} == 4'b0000)
            else fail_value("reset_lines", 32'h0, 32'({busy, pin30, cart_bk1}));
        assert ({bk0_dir, pin30_dir, pin31_dir} == 3'b010)
            else fail_value("reset_dirs", 32'h2, 32'({bk0_dir, pin30_dir, pin31_dir}));
    endtask

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        fail_plain("Watchdog timeout, the frames stopped coming");
    end

    initial begin
        void'($urandom(32'h7c90));
        rst       = 1'b1;
        cur_type  = GC_DISABLED;
        cur_rate  = RATE_COMPAT;
        pat1      = '0;
        pat2      = '0;
        test_name = "reset";
        repeat (RST_CYC) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_reset_state();

        test_name = "nes_frames";
        new_patterns();
        set_mode(GC_NES, RATE_COMPAT);
        wait_frames(3);

        test_name = "snes_frames";
        set_mode(GC_SNES, RATE_FAST);
        wait_frames(4);

        test_name = "disabled";
        set_mode(GC_DISABLED, RATE_FAST);
        repeat (200) @(negedge clk);

        test_name = "reenabled";
        set_mode(GC_SNES, RATE_VFAST);
        wait_frames(3);

        // Polling ratio vfast/normal is 5, so 4x leaves room for rounding
        test_name = "rate_ratio";
        count_latches(RATE_NORMAL, n_normal);
        count_latches(RATE_VFAST, n_vfast);
        assert (n_normal > 0)
            else fail_plain("No latch pulses seen in normal mode");
        assert (n_vfast >= 4 * n_normal)
            else fail_value(test_name, 32'(4 * n_normal), 32'(n_vfast));

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- verification/snac_pad_model.sv
`timescale 1ns/1ps

module snac_pad_model (
    input  logic                     i_lat,      // Shared latch from bank1[7]
    input  logic                     i_pad_clk,  // Shared pad clock from bank1[6]
    input  serlatch_pkg::btn_state_t i_pattern,  // Bit k high when button k is held
    output logic                     o_dat       // Serial data, active low
);
    import serlatch_pkg::*;

    // Shift register inside the pad, bit 0 goes out first
    btn_state_t shift_q = '0;

    // Latch loads the buttons, each rising pad clock moves to the next one
    always @(posedge i_lat or posedge i_pad_clk) begin
        if (i_lat) begin
            shift_q <= i_pattern;
        end else begin
            shift_q <= shift_q >> 1;   // Empty slots read as released
        end
    end

    assign o_dat = ~shift_q[0];        // Pressed button pulls the line low

endmodule
